//--- rtl/id_pkg.sv
/*
 * instruction decode package
 * widths, instruction field positions, status flag bits and the
 * opcode, condition and alu enums shared by the decode stage
 */
package id_pkg;

    localparam int data_w     = 32;             // word width
    localparam int reg_addr_w = 3;              // 8 registers
    localparam int imm_w      = 16;             // immediate and branch offset field

    // instruction field positions
    localparam int op_msb   = 31;               // top of the 7-bit major opcode
    localparam int op_lsb   = 25;
    localparam int dest_lsb = 22;               // dest, store source, branch pointer
    localparam int op1_lsb  = 19;               // mem pointer, shift source, operand 1
    localparam int op2_lsb  = 16;               // operand 2
    localparam int cond_lsb = 21;               // 4-bit branch condition
    localparam int alu_lsb  = 25;               // 3-bit alu code, S bit sits above it

    // cpsr flag bits
    localparam int flag_n = 31;
    localparam int flag_z = 30;
    localparam int flag_c = 29;
    localparam int flag_v = 28;

    localparam int branch_shift = 2;            // offsets count words

    // major opcodes, bits 31..25; don't-care bits encode as 0
    typedef enum logic [6:0] {
        op_load  = 7'b1000000,
        op_stor  = 7'b1000001,
        op_mov   = 7'b0000000,
        op_movt  = 7'b0000001,
        op_add   = 7'b0010001,
        op_adds  = 7'b0011001,
        op_sub   = 7'b0010010,
        op_subs  = 7'b0011010,
        op_and   = 7'b0010011,
        op_ands  = 7'b0011011,
        op_or    = 7'b0010100,
        op_ors   = 7'b0011100,
        op_xor   = 7'b0010101,
        op_xors  = 7'b0011101,
        op_lsl   = 7'b0000100,
        op_lsr   = 7'b0000101,
        op_clr   = 7'b0000010,
        op_set   = 7'b0000011,
        op_add2  = 7'b0110001,
        op_adds2 = 7'b0111001,
        op_sub2  = 7'b0110010,
        op_subs2 = 7'b0111010,
        op_and2  = 7'b0110011,
        op_ands2 = 7'b0111011,
        op_or2   = 7'b0110100,
        op_ors2  = 7'b0111100,
        op_xor2  = 7'b0110101,
        op_xors2 = 7'b0111101,
        op_not   = 7'b0110110,
        op_b     = 7'b1100000,
        op_bcond = 7'b1100001,
        op_br    = 7'b1100010,
        op_nop   = 7'b1100100,
        op_halt  = 7'b1101000
    } instr_op_e;

    // branch conditions, 12..15 never pass
    typedef enum logic [3:0] {
        cond_eq, cond_ne, cond_cs, cond_cc,
        cond_mi, cond_pl, cond_vs, cond_vc,
        cond_hi, cond_ls, cond_ge, cond_lt
    } cond_e;

    // alu function codes, bits 27..25
    typedef enum logic [2:0] {
        alu_add = 3'd1,
        alu_sub = 3'd2,
        alu_and = 3'd3,
        alu_or  = 3'd4,
        alu_xor = 3'd5,
        alu_not = 3'd6
    } alu_op_e;

endpackage

//--- rtl/cond_check.sv
/*
 * branch condition check
 * tests a 4-bit condition code against the N Z C V status flags
 */
module cond_check (
    input  id_pkg::cond_e cond,                 // condition field of Bcond
    input  logic [3:0]    flags,                // {N, Z, C, V}
    output logic          cond_true
);

    logic n, z, c, v;

    assign n = flags[3];
    assign z = flags[2];
    assign c = flags[1];
    assign v = flags[0];

    always_comb begin
        case (cond)
            id_pkg::cond_eq: cond_true = z;
            id_pkg::cond_ne: cond_true = !z;
            id_pkg::cond_cs: cond_true = c;
            id_pkg::cond_cc: cond_true = !c;
            id_pkg::cond_mi: cond_true = n;
            id_pkg::cond_pl: cond_true = !n;
            id_pkg::cond_vs: cond_true = v;
            id_pkg::cond_vc: cond_true = !v;
            id_pkg::cond_hi: cond_true = !z && c;
            id_pkg::cond_ls: cond_true = !(!z && c);  // inverse of hi
            id_pkg::cond_ge: cond_true = (n == z);    // N/Z pairing of the ISA
            id_pkg::cond_lt: cond_true = (n != z);
            default:         cond_true = 1'b0;        // reserved codes
        endcase
    end

endmodule

//--- rtl/branch_unit.sv
/*
 * branch unit
 * decides whether B, Bcond or BR is taken and forms the new pc,
 * base plus the sign-extended word offset
 */
module branch_unit (
    input  logic [id_pkg::data_w-1:0] instruction,
    input  logic [id_pkg::data_w-1:0] cpsr_val,
    input  logic [id_pkg::data_w-1:0] pc_val,
    input  logic [id_pkg::data_w-1:0] reg1_val,     // branch pointer register for BR
    output logic                      branch_take,
    output logic [id_pkg::data_w-1:0] branch_target
);

    id_pkg::instr_op_e         op;
    logic                      cond_true;
    logic [id_pkg::data_w-1:0] offset;
    logic [id_pkg::data_w-1:0] base;

    assign op = id_pkg::instr_op_e'(instruction[id_pkg::op_msb:id_pkg::op_lsb]);

    cond_check u_cond (
        .cond      (id_pkg::cond_e'(instruction[id_pkg::cond_lsb +: 4])),
        .flags     ({cpsr_val[id_pkg::flag_n], cpsr_val[id_pkg::flag_z],
                     cpsr_val[id_pkg::flag_c], cpsr_val[id_pkg::flag_v]}),
        .cond_true (cond_true)
    );

    // sign extend then scale to a word address
    assign offset = {{(id_pkg::data_w - id_pkg::imm_w){instruction[id_pkg::imm_w-1]}},
                     instruction[id_pkg::imm_w-1:0]} << id_pkg::branch_shift;

    assign base          = (op == id_pkg::op_br) ? reg1_val : pc_val;
    assign branch_target = base + offset;

    assign branch_take = (op == id_pkg::op_b) || (op == id_pkg::op_br) ||
                         ((op == id_pkg::op_bcond) && cond_true);

endmodule

//--- rtl/reg_data_gen.sv
/*
 * register write data generator
 * data the decoder writes itself for MOV, MOVT, LSL, LSR, CLR and SET
 */
module reg_data_gen (
    input  logic [id_pkg::data_w-1:0] instruction,
    input  logic [id_pkg::data_w-1:0] reg1_val,     // dest for MOV/MOVT, shift source for LSL/LSR
    output logic [id_pkg::data_w-1:0] gen_data
);

    localparam int half_w = id_pkg::data_w / 2;

    id_pkg::instr_op_e        op;
    logic [id_pkg::imm_w-1:0] imm;

    assign op  = id_pkg::instr_op_e'(instruction[id_pkg::op_msb:id_pkg::op_lsb]);
    assign imm = instruction[id_pkg::imm_w-1:0];

    always_comb begin
        case (op)
            id_pkg::op_mov:  gen_data = {reg1_val[id_pkg::data_w-1:half_w], imm}; // low half
            id_pkg::op_movt: gen_data = {imm, reg1_val[half_w-1:0]};              // high half
            id_pkg::op_lsl:  gen_data = reg1_val << imm;     // 32 and up shifts everything out
            id_pkg::op_lsr:  gen_data = reg1_val >> imm;
            id_pkg::op_clr:  gen_data = '0;
            id_pkg::op_set:  gen_data = '1;
            default:         gen_data = '0;
        endcase
    end

endmodule

//--- rtl/ctrl_decode.sv
/*
 * control decoder
 * turns the major opcode into register file, alu and data memory controls
 */
module ctrl_decode (
    input  logic [id_pkg::data_w-1:0]     instruction,
    input  logic [id_pkg::data_w-1:0]     reg1_val,
    input  logic [id_pkg::data_w-1:0]     reg2_val,
    output logic [id_pkg::reg_addr_w-1:0] read_addr1,
    output logic [id_pkg::reg_addr_w-1:0] read_addr2,
    output logic [id_pkg::reg_addr_w-1:0] write_addr,
    output logic                          write_data_sel,  // 1 = alu result, 0 = from decode
    output logic                          write_enable,
    output logic                          wr_cpsr,
    output logic                          data_read,
    output logic                          data_write,
    output logic [id_pkg::data_w-1:0]     data_addr,
    output logic [id_pkg::data_w-1:0]     data_out,
    output id_pkg::alu_op_e               opcode,
    output logic [id_pkg::data_w-1:0]     operand2,
    output logic                          ir_op,           // 1 = register second operand
    output logic                          halt_req
);

    id_pkg::instr_op_e                op;
    logic [id_pkg::reg_addr_w-1:0]    dest;
    logic [id_pkg::reg_addr_w-1:0]    op1;
    logic [id_pkg::reg_addr_w-1:0]    op2;
    logic [id_pkg::data_w-1:0]        imm_ext;
    logic                             s_bit;

    assign op      = id_pkg::instr_op_e'(instruction[id_pkg::op_msb:id_pkg::op_lsb]);
    assign dest    = instruction[id_pkg::dest_lsb +: id_pkg::reg_addr_w];
    assign op1     = instruction[id_pkg::op1_lsb +: id_pkg::reg_addr_w];
    assign op2     = instruction[id_pkg::op2_lsb +: id_pkg::reg_addr_w];
    assign imm_ext = {{(id_pkg::data_w - id_pkg::imm_w){1'b0}},
                      instruction[id_pkg::imm_w-1:0]};        // zero extended
    assign s_bit   = instruction[id_pkg::alu_lsb + 3];        // status update variants

    always_comb begin
        read_addr1     = '0;                    // everything idles unless decoded
        read_addr2     = '0;
        write_addr     = '0;
        write_data_sel = 1'b0;
        write_enable   = 1'b0;
        wr_cpsr        = 1'b0;
        data_read      = 1'b0;
        data_write     = 1'b0;
        data_addr      = '0;
        data_out       = '0;
        opcode         = id_pkg::alu_op_e'(3'd0);
        operand2       = '0;
        ir_op          = 1'b0;
        halt_req       = 1'b0;

        case (op)
            id_pkg::op_load: begin
                read_addr1   = op1;             // pointer
                write_addr   = dest;
                write_enable = 1'b1;            // loaded word comes back from data memory
                data_addr    = reg1_val + imm_ext;
                data_read    = 1'b1;
            end
            id_pkg::op_stor: begin
                read_addr1 = dest;              // source word
                read_addr2 = op1;               // pointer
                data_addr  = reg2_val + imm_ext;
                data_out   = reg1_val;
                data_write = 1'b1;
            end
            id_pkg::op_mov, id_pkg::op_movt: begin
                read_addr1   = dest;            // other half is kept
                write_addr   = dest;
                write_enable = 1'b1;
            end
            id_pkg::op_lsl, id_pkg::op_lsr: begin
                read_addr1   = op1;             // shift source
                write_addr   = dest;
                write_enable = 1'b1;
            end
            id_pkg::op_clr, id_pkg::op_set: begin
                write_addr   = dest;
                write_enable = 1'b1;
            end
            id_pkg::op_add, id_pkg::op_adds, id_pkg::op_sub, id_pkg::op_subs,
            id_pkg::op_and, id_pkg::op_ands, id_pkg::op_or, id_pkg::op_ors,
            id_pkg::op_xor, id_pkg::op_xors: begin
                opcode         = id_pkg::alu_op_e'(instruction[id_pkg::alu_lsb +: 3]);
                read_addr1     = op1;
                operand2       = imm_ext;       // immediate operand, ir_op stays 0
                write_addr     = dest;
                write_data_sel = 1'b1;
                write_enable   = 1'b1;
                wr_cpsr        = s_bit;
            end
            id_pkg::op_add2, id_pkg::op_adds2, id_pkg::op_sub2, id_pkg::op_subs2,
            id_pkg::op_and2, id_pkg::op_ands2, id_pkg::op_or2, id_pkg::op_ors2,
            id_pkg::op_xor2, id_pkg::op_xors2: begin
                opcode         = id_pkg::alu_op_e'(instruction[id_pkg::alu_lsb +: 3]);
                read_addr1     = op1;
                read_addr2     = op2;
                ir_op          = 1'b1;
                write_addr     = dest;
                write_data_sel = 1'b1;
                write_enable   = 1'b1;
                wr_cpsr        = s_bit;
            end
            id_pkg::op_not: begin
                opcode         = id_pkg::alu_op_e'(instruction[id_pkg::alu_lsb +: 3]);
                read_addr1     = op1;           // single operand
                ir_op          = 1'b1;
                write_addr     = dest;
                write_data_sel = 1'b1;
                write_enable   = 1'b1;
            end
            id_pkg::op_br: begin
                read_addr1 = dest;              // branch pointer, target formed in branch_unit
            end
            id_pkg::op_halt: begin
                halt_req = 1'b1;
            end
            default: begin
                // B, Bcond, NOP and undefined codes drive no controls here
            end
        endcase
    end

endmodule

//--- rtl/id_stage.sv
/*
 * instruction decode stage
 * joins the decoders, registers their outputs for one cycle of latency
 * and keeps the sticky halt flag that masks every enable
 */
module id_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [id_pkg::data_w-1:0]     instruction,
    input  logic [id_pkg::data_w-1:0]     reg1_val,
    input  logic [id_pkg::data_w-1:0]     reg2_val,
    input  logic [id_pkg::data_w-1:0]     cpsr_val,
    input  logic [id_pkg::data_w-1:0]     pc_val,
    output logic [id_pkg::reg_addr_w-1:0] read_addr1,   // same cycle as instruction
    output logic [id_pkg::reg_addr_w-1:0] read_addr2,
    output logic [id_pkg::reg_addr_w-1:0] write_addr,
    output logic [id_pkg::data_w-1:0]     write_data,
    output logic                          write_data_sel,
    output logic                          write_enable,
    output logic                          wr_cpsr,
    output logic [id_pkg::data_w-1:0]     data_addr,
    output logic                          data_read,
    output logic                          data_write,
    output logic [id_pkg::data_w-1:0]     data_out,
    output id_pkg::alu_op_e               opcode,
    output logic [id_pkg::data_w-1:0]     operand2,
    output logic                          ir_op,
    output logic                          wr_pc,
    output logic [id_pkg::data_w-1:0]     wr_pc_val,
    output logic                          halt_flag
);

    logic [id_pkg::reg_addr_w-1:0] nxt_write_addr;
    logic                          nxt_write_data_sel;
    logic                          nxt_write_enable;
    logic                          nxt_wr_cpsr;
    logic                          nxt_data_read;
    logic                          nxt_data_write;
    logic [id_pkg::data_w-1:0]     nxt_data_addr;
    logic [id_pkg::data_w-1:0]     nxt_data_out;
    id_pkg::alu_op_e               nxt_opcode;
    logic [id_pkg::data_w-1:0]     nxt_operand2;
    logic                          nxt_ir_op;
    logic                          halt_req;
    logic [id_pkg::data_w-1:0]     gen_data;
    logic                          branch_take;
    logic [id_pkg::data_w-1:0]     branch_target;
    logic                          id_write;
    logic [id_pkg::data_w-1:0]     nxt_write_data;

    ctrl_decode u_ctrl (
        .instruction    (instruction),
        .reg1_val       (reg1_val),
        .reg2_val       (reg2_val),
        .read_addr1     (read_addr1),
        .read_addr2     (read_addr2),
        .write_addr     (nxt_write_addr),
        .write_data_sel (nxt_write_data_sel),
        .write_enable   (nxt_write_enable),
        .wr_cpsr        (nxt_wr_cpsr),
        .data_read      (nxt_data_read),
        .data_write     (nxt_data_write),
        .data_addr      (nxt_data_addr),
        .data_out       (nxt_data_out),
        .opcode         (nxt_opcode),
        .operand2       (nxt_operand2),
        .ir_op          (nxt_ir_op),
        .halt_req       (halt_req)
    );

    reg_data_gen u_gen (
        .instruction (instruction),
        .reg1_val    (reg1_val),
        .gen_data    (gen_data)
    );

    branch_unit u_branch (
        .instruction   (instruction),
        .cpsr_val      (cpsr_val),
        .pc_val        (pc_val),
        .reg1_val      (reg1_val),
        .branch_take   (branch_take),
        .branch_target (branch_target)
    );

    // register writes sourced by the decoder itself, loads excluded
    assign id_write       = nxt_write_enable && !nxt_write_data_sel && !nxt_data_read;
    assign nxt_write_data = id_write ? gen_data : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            write_addr     <= '0;
            write_data     <= '0;
            write_data_sel <= 1'b0;
            write_enable   <= 1'b0;
            wr_cpsr        <= 1'b0;
            data_addr      <= '0;
            data_read      <= 1'b0;
            data_write     <= 1'b0;
            data_out       <= '0;
            opcode         <= id_pkg::alu_op_e'(3'd0);
            operand2       <= '0;
            ir_op          <= 1'b0;
            wr_pc          <= 1'b0;
            wr_pc_val      <= '0;
            halt_flag      <= 1'b0;
        end else begin
            write_addr     <= nxt_write_addr;
            write_data     <= nxt_write_data;
            write_data_sel <= nxt_write_data_sel;
            write_enable   <= nxt_write_enable && !halt_flag;   // halted stage issues nothing
            wr_cpsr        <= nxt_wr_cpsr && !halt_flag;
            data_addr      <= nxt_data_addr;
            data_read      <= nxt_data_read && !halt_flag;
            data_write     <= nxt_data_write && !halt_flag;
            data_out       <= nxt_data_out;
            opcode         <= nxt_opcode;
            operand2       <= nxt_operand2;
            ir_op          <= nxt_ir_op;
            wr_pc          <= branch_take && !halt_flag;
            wr_pc_val      <= branch_target;
            if (halt_req) begin
                halt_flag <= 1'b1;                              // sticky until reset
            end
        end
    end

    // memory read and write come out of one decode, never together
    a_mem_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(nxt_data_read && nxt_data_write));

    // pc update and register write come from different decoders
    a_pc_vs_reg: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr_pc && write_enable));

    a_halt_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        $past(halt_flag) |-> !(write_enable || wr_cpsr || data_read || data_write || wr_pc));

endmodule

//--- verif/tb_clkgen.sv
/*
 * testbench clock and reset generator
 * 100 ns clock, rst_n held low for the first 5 cycles
 */
module tb_clkgen (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int reset_cycles = 5;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                 // half of the 100 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);                         // release away from the active edge
        rst_n = 1'b1;
    end

endmodule

//--- verif/tb_id_stage.sv
/*
 * id_stage testbench
 * directed tests on the decode stage with a model register file,
 * expected values worked out from the instruction rules
 */
module tb_id_stage;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int max_cycles = 2000;           // about 250 cycles of tests

    logic        clk, rst_n;
    logic [31:0] instruction, reg1_val, reg2_val, cpsr_val, pc_val;
    logic [2:0]  read_addr1, read_addr2, write_addr;
    logic [31:0] write_data, data_addr, data_out, operand2, wr_pc_val;
    logic        write_data_sel, write_enable, wr_cpsr, data_read, data_write;
    logic        ir_op, wr_pc, halt_flag;
    id_pkg::alu_op_e opcode;

    logic [31:0] regs [8];                      // model register file
    int          seed = 73652;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    tb_clkgen u_clkgen (.clk(clk), .rst_n(rst_n));

    id_stage dut0 (
        .clk(clk), .rst_n(rst_n), .instruction(instruction),
        .reg1_val(reg1_val), .reg2_val(reg2_val), .cpsr_val(cpsr_val), .pc_val(pc_val),
        .read_addr1(read_addr1), .read_addr2(read_addr2), .write_addr(write_addr),
        .write_data(write_data), .write_data_sel(write_data_sel),
        .write_enable(write_enable), .wr_cpsr(wr_cpsr), .data_addr(data_addr),
        .data_read(data_read), .data_write(data_write), .data_out(data_out),
        .opcode(opcode), .operand2(operand2), .ir_op(ir_op), .wr_pc(wr_pc),
        .wr_pc_val(wr_pc_val), .halt_flag(halt_flag)
    );

    assign reg1_val = regs[read_addr1];         // register file reads are combinational
    assign reg2_val = regs[read_addr2];

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: tests still running after %0d clock cycles", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] make_instr(input logic [6:0] op, input logic [2:0] rd,
                                               input logic [2:0] ra, input logic [2:0] rb,
                                               input logic [15:0] imm);
        return {op, rd, ra, rb, imm};           // op 31..25, fields, immediate 15..0
    endfunction

    // branch condition rule on N Z C V
    function automatic logic cond_rule(input logic [3:0] code, input logic [31:0] cpsr);
        logic n, z, c, v;
        n = cpsr[31];
        z = cpsr[30];
        c = cpsr[29];
        v = cpsr[28];
        case (code)
            4'd0:    cond_rule = z;
            4'd1:    cond_rule = !z;
            4'd2:    cond_rule = c;
            4'd3:    cond_rule = !c;
            4'd4:    cond_rule = n;
            4'd5:    cond_rule = !n;
            4'd6:    cond_rule = v;
            4'd7:    cond_rule = !v;
            4'd8:    cond_rule = c && !z;
            4'd9:    cond_rule = !c || z;
            4'd10:   cond_rule = (n == z);      // GE pairs N with Z
            4'd11:   cond_rule = (n != z);
            default: cond_rule = 1'b0;          // 12..15 never taken
        endcase
    endfunction

    task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // order {write_enable, wr_cpsr, data_read, data_write, wr_pc}
    task automatic check_enables(input string what, input logic [4:0] exp);
        logic [4:0] got;
        got = {write_enable, wr_cpsr, data_read, data_write, wr_pc};
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s enables are %b, expected %b", $time, what, got, exp);
        end
    endtask

    // called on a falling edge; returns on the next one, outputs registered
    task automatic issue(input logic [31:0] instr);
        instruction = instr;
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic fill_regs();
        int k;
        for (k = 0; k < 8; k++) begin
            regs[k] = $random(seed);
        end
    endtask

    task automatic alu_case(input logic [6:0] op, input logic reg_form, input logic s_form,
                            input logic two_src);
        logic [2:0]  rd, ra, rb;
        logic [15:0] imm;
        logic [31:0] instr;
        rd = 3'($random(seed));
        ra = 3'($random(seed));
        rb = 3'($random(seed));
        imm = 16'($random(seed));
        instr = make_instr(op, rd, ra, rb, imm);
        issue(instr);
        check_val("alu opcode", 32'(opcode), {29'd0, instr[27:25]});
        check_val("alu ir_op", 32'(ir_op), 32'(reg_form));
        check_val("alu operand2", operand2, reg_form ? 32'd0 : {16'd0, imm});
        check_val("alu write_addr", 32'(write_addr), 32'(rd));
        check_val("alu write_data_sel", 32'(write_data_sel), 32'd1);
        check_val("alu read_addr1", 32'(read_addr1), 32'(ra));
        check_val("alu read_addr2", 32'(read_addr2), two_src ? 32'(rb) : 32'd0);
        check_enables("alu", {1'b1, s_form, 3'b000});
    endtask

    task automatic alu_tests();
        int pass, c, s, r;
        for (pass = 0; pass < 2; pass++) begin
            for (c = 1; c <= 5; c++) begin
                for (s = 0; s < 2; s++) begin
                    for (r = 0; r < 2; r++) begin
                        // 0 R 1 S ccc, R picks the register form
                        alu_case({1'b0, 1'(r), 1'b1, 1'(s), 3'(c)}, 1'(r), 1'(s), 1'(r));
                    end
                end
            end
            alu_case(id_pkg::op_not, 1'b1, 1'b0, 1'b0);
        end
    endtask

    task automatic gen_one(input logic [31:0] instr, input logic [2:0] rd,
                           input logic [31:0] exp);
        issue(instr);
        check_val("gen write_data", write_data, exp);
        check_val("gen write_addr", 32'(write_addr), 32'(rd));
        check_val("gen write_data_sel", 32'(write_data_sel), 32'd0);
        check_enables("gen", 5'b10000);
    endtask

    task automatic gen_tests();
        int          i;
        logic [2:0]  rd, ra;
        logic [15:0] imm, amt;
        for (i = 0; i < 10; i++) begin
            fill_regs();
            rd = 3'($random(seed));
            ra = 3'($random(seed));
            imm = 16'($random(seed));
            case (i)
                0:       amt = 16'd0;
                1:       amt = 16'd31;
                2:       amt = 16'd32;          // everything shifted out
                3:       amt = 16'hffff;
                default: amt = 16'($random(seed)) & 16'h003f;
            endcase
            gen_one(make_instr(id_pkg::op_mov, rd, ra, 3'd0, imm), rd,
                    {regs[rd][31:16], imm});
            gen_one(make_instr(id_pkg::op_movt, rd, ra, 3'd0, imm), rd,
                    {imm, regs[rd][15:0]});
            gen_one(make_instr(id_pkg::op_lsl, rd, ra, 3'd0, amt), rd,
                    (amt >= 16'd32) ? 32'd0 : regs[ra] << amt);
            gen_one(make_instr(id_pkg::op_lsr, rd, ra, 3'd0, amt), rd,
                    (amt >= 16'd32) ? 32'd0 : regs[ra] >> amt);
            gen_one(make_instr(id_pkg::op_clr, rd, ra, 3'd0, imm), rd, 32'd0);
            gen_one(make_instr(id_pkg::op_set, rd, ra, 3'd0, imm), rd, 32'hffff_ffff);
        end
    endtask

    task automatic mem_tests();
        int          i;
        logic [2:0]  rd, ra;
        logic [15:0] imm;
        for (i = 0; i < 8; i++) begin
            fill_regs();
            rd = 3'($random(seed));
            ra = 3'($random(seed));
            imm = 16'($random(seed));
            issue(make_instr(id_pkg::op_load, rd, ra, 3'd0, imm));
            check_val("load data_addr", data_addr, regs[ra] + {16'd0, imm});
            check_val("load write_addr", 32'(write_addr), 32'(rd));
            check_enables("load", 5'b10100);
            issue(make_instr(id_pkg::op_stor, rd, ra, 3'd0, imm));  // rd is the source
            check_val("stor data_addr", data_addr, regs[ra] + {16'd0, imm});
            check_val("stor data_out", data_out, regs[rd]);
            check_enables("stor", 5'b00010);
        end
    endtask

    task automatic branch_tests();
        int          i, code, k;
        logic [2:0]  rd;
        logic [15:0] imm;
        logic [31:0] off;
        logic        take;
        for (i = 0; i < 8; i++) begin
            fill_regs();
            pc_val = $random(seed);
            rd = 3'($random(seed));
            imm = 16'($random(seed)) | (i[0] ? 16'h8000 : 16'h0000);  // odd rounds go back
            off = {{16{imm[15]}}, imm};
            issue(make_instr(id_pkg::op_b, 3'd0, 3'd0, 3'd0, imm));
            check_val("b target", wr_pc_val, pc_val + off * 32'd4);
            check_enables("b", 5'b00001);
            issue(make_instr(id_pkg::op_br, rd, 3'd0, 3'd0, imm));
            check_val("br target", wr_pc_val, regs[rd] + off * 32'd4);
            check_enables("br", 5'b00001);
        end
        for (code = 0; code < 16; code++) begin
            for (k = 0; k < 4; k++) begin
                cpsr_val = $random(seed);
                pc_val = $random(seed);
                imm = 16'($random(seed));
                off = {{16{imm[15]}}, imm};
                take = cond_rule(4'(code), cpsr_val);
                issue({id_pkg::op_bcond, 4'(code), 5'd0, imm});
                check_enables("bcond", {4'b0000, take});
                if (take) begin
                    check_val("bcond target", wr_pc_val, pc_val + off * 32'd4);
                end
            end
        end
    endtask

    task automatic halt_tests();
        issue(make_instr(id_pkg::op_nop, 3'd1, 3'd2, 3'd3, 16'h1234));
        check_enables("nop", 5'b00000);
        issue({7'h7f, 25'h0abcdef});            // no instruction uses this code
        check_enables("undefined", 5'b00000);
        check_val("halt_flag before halt", 32'(halt_flag), 32'd0);
        issue(make_instr(id_pkg::op_halt, 3'd0, 3'd0, 3'd0, 16'h0000));
        check_val("halt_flag after halt", 32'(halt_flag), 32'd1);
        check_enables("halt", 5'b00000);
        issue(make_instr(id_pkg::op_adds2, 3'd1, 3'd2, 3'd3, 16'h0000));
        check_enables("add after halt", 5'b00000);
        issue(make_instr(id_pkg::op_load, 3'd4, 3'd5, 3'd0, 16'h0010));
        check_enables("load after halt", 5'b00000);
        issue(make_instr(id_pkg::op_stor, 3'd6, 3'd7, 3'd0, 16'h0020));
        check_enables("stor after halt", 5'b00000);
        issue(make_instr(id_pkg::op_b, 3'd0, 3'd0, 3'd0, 16'h0040));
        check_enables("b after halt", 5'b00000);
        check_val("halt_flag held", 32'(halt_flag), 32'd1);
    endtask

    initial begin
        instruction = {id_pkg::op_nop, 25'd0};
        cpsr_val = 32'd0;
        pc_val = 32'd0;
        fill_regs();
        @(posedge rst_n);                       // released on a falling edge
        check_enables("reset", 5'b00000);
        check_val("reset halt_flag", 32'(halt_flag), 32'd0);
        alu_tests();
        gen_tests();
        mem_tests();
        branch_tests();
        halt_tests();
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- sources.f
rtl/id_pkg.sv
rtl/cond_check.sv
rtl/branch_unit.sv
rtl/reg_data_gen.sv
rtl/ctrl_decode.sv
rtl/id_stage.sv
verif/tb_clkgen.sv
verif/tb_id_stage.sv

//--- run.sh
#!/bin/sh
# compile and run the id_stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sources.f --top-module tb_id_stage -o tb_id_stage
out=$(./obj_dir/tb_id_stage 2>&1) || { printf '%s\n' "$out"; exit 1; }
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
exit 1
